//--- verilog/corr_cfg_pkg.sv
`default_nettype none

package corr_cfg_pkg;

	// Every count in the design, the window length included, has this width
	localparam int CNT_W = 16;

	// One byte goes out per byte tick
	localparam int BYTE_W = 8;

	localparam int DEF_NUM_INPUTS = 4; // Detector lines
	localparam int DEF_NUM_LAGS = 4;   // Lags 0 to DEF_NUM_LAGS-1

	// First header byte of every packet
	localparam logic [BYTE_W-1:0] PKT_SYNC = 8'hA5;

	// Sync byte, line count and lag count come ahead of the counts
	localparam int PKT_HDR_BYTES = 3;

endpackage

`default_nettype wire

//--- verilog/corr_types_pkg.sv
`default_nettype none

package corr_types_pkg;

	typedef logic [corr_cfg_pkg::CNT_W-1:0] cnt_t;

	// Window control as seen by every block after the sampler
	typedef struct packed {
		logic counting; // High through the window
		logic start;    // First window cycle
		logic stop;     // First cycle after the window
	} window_ctrl_t;

	typedef struct packed {
		logic strobe;
		logic [corr_cfg_pkg::BYTE_W-1:0] data;
	} tx_out_t;

	// Next value of a saturating count that clears and may step in the same cycle
	function automatic cnt_t cnt_step(input cnt_t cnt, input logic clear, input logic inc);
		cnt_t base;
		base = clear ? '0 : cnt;
		if (inc && base != '1) begin
			base = base + 1'b1;
		end
		return base;
	endfunction

endpackage

`default_nettype wire

//--- verilog/line_sampler.sv
`default_nettype none

module line_sampler #(
	parameter int NUM_INPUTS = corr_cfg_pkg::DEF_NUM_INPUTS
) (
	input wire intclk,
	input wire rst_n,
	input wire [NUM_INPUTS-1:0] line_in,
	input wire integrate,
	input wire invert,
	output logic [NUM_INPUTS-1:0] pulses,
	output corr_types_pkg::window_ctrl_t window
);

	// Invert and integrate ride in the same two-flop chain as the lines
	logic [NUM_INPUTS+1:0] sync1;
	logic [NUM_INPUTS+1:0] sync2;
	logic [NUM_INPUTS-1:0] level;
	logic [NUM_INPUTS-1:0] level_q;
	logic integ_s;
	logic integ_q;
	logic inv_s;

	assign integ_s = sync2[NUM_INPUTS];
	assign inv_s = sync2[NUM_INPUTS+1];
	assign level = sync2[NUM_INPUTS-1:0] ^ {NUM_INPUTS{inv_s}};

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			sync1 <= '0;
			sync2 <= '0;
			level_q <= '0;
			integ_q <= 1'b0;
			pulses <= '0;
			window <= '0;
		end else begin
			sync1 <= {invert, integrate, line_in};
			sync2 <= sync1;
			level_q <= level;
			integ_q <= integ_s;

			// Rising edges of the possibly inverted lines, one cycle each
			pulses <= level & ~level_q;

			// Window control lines up with the pulses, three cycles after the input
			window.counting <= integ_s;
			window.start <= integ_s & ~integ_q;
			window.stop <= ~integ_s & integ_q;
		end
	end

endmodule

`default_nettype wire

//--- verilog/pulse_counter.sv
`default_nettype none

module pulse_counter #(
	parameter int NUM_INPUTS = corr_cfg_pkg::DEF_NUM_INPUTS
) (
	input wire intclk,
	input wire rst_n,
	input wire [NUM_INPUTS-1:0] pulses,
	input wire corr_types_pkg::window_ctrl_t window,
	output corr_types_pkg::cnt_t [NUM_INPUTS-1:0] line_counts
);

	logic [NUM_INPUTS-1:0] counted;

	// Only pulses that fall inside the window are counted
	assign counted = pulses & {NUM_INPUTS{window.counting}};

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			line_counts <= '0;
		end else begin
			for (int n = 0; n < NUM_INPUTS; n++) begin
				// A pulse on the start cycle counts as the first one of the new window
				line_counts[n] <= corr_types_pkg::cnt_step(line_counts[n], window.start,
					counted[n]);
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/lag_correlator.sv
`default_nettype none

module lag_correlator #(
	parameter int NUM_INPUTS = corr_cfg_pkg::DEF_NUM_INPUTS,
	parameter int NUM_LAGS = corr_cfg_pkg::DEF_NUM_LAGS
) (
	input wire intclk,
	input wire rst_n,
	input wire [NUM_INPUTS-1:0] pulses,
	input wire corr_types_pkg::window_ctrl_t window,
	output corr_types_pkg::cnt_t [NUM_INPUTS*(NUM_INPUTS-1)/2*NUM_LAGS-1:0] pair_counts
);

	localparam int NUM_PAIRS = NUM_INPUTS * (NUM_INPUTS - 1) / 2;
	localparam int NUM_CNT = NUM_PAIRS * NUM_LAGS;
	// Lag 0 is taken straight from the present pulse
	localparam int HIST_W = (NUM_LAGS > 1) ? NUM_LAGS - 1 : 1;

	logic [NUM_INPUTS-1:0] win_pulses;
	logic [HIST_W-1:0] hist [NUM_INPUTS];
	logic [HIST_W:0] taps [NUM_INPUTS];
	logic [NUM_CNT-1:0] hit;

	assign win_pulses = pulses & {NUM_INPUTS{window.counting}};

	genvar i, j, k;
	generate
		for (j = 0; j < NUM_INPUTS; j++) begin : tap_g
			// Bit k is the pulse k cycles back, and nothing older than the window start
			assign taps[j] = {hist[j] & {HIST_W{~window.start}}, win_pulses[j]};
		end

		for (i = 0; i < NUM_INPUTS; i++) begin : first_g
			for (j = i + 1; j < NUM_INPUTS; j++) begin : second_g
				// Pairs run i major with j above i
				localparam int PAIR = i * NUM_INPUTS - (i * (i + 1)) / 2 + (j - i - 1);
				for (k = 0; k < NUM_LAGS; k++) begin : lag_g
					assign hit[PAIR*NUM_LAGS+k] = win_pulses[i] & taps[j][k];
				end
			end
		end
	endgenerate

	// History holds window pulses only and starts empty in each window
	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			for (int n = 0; n < NUM_INPUTS; n++) begin
				hist[n] <= '0;
			end
		end else begin
			for (int n = 0; n < NUM_INPUTS; n++) begin
				if (window.start) begin
					hist[n] <= HIST_W'(win_pulses[n]);
				end else begin
					hist[n] <= HIST_W'({hist[n], win_pulses[n]});
				end
			end
		end
	end

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			pair_counts <= '0;
		end else begin
			for (int n = 0; n < NUM_CNT; n++) begin
				pair_counts[n] <= corr_types_pkg::cnt_step(pair_counts[n], window.start,
					hit[n]);
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/packet_builder.sv
`default_nettype none

module packet_builder #(
	parameter int NUM_INPUTS = corr_cfg_pkg::DEF_NUM_INPUTS,
	parameter int NUM_LAGS = corr_cfg_pkg::DEF_NUM_LAGS
) (
	input wire intclk,
	input wire rst_n,
	input wire corr_types_pkg::window_ctrl_t window,
	input wire corr_types_pkg::cnt_t [NUM_INPUTS-1:0] line_counts,
	input wire corr_types_pkg::cnt_t [NUM_INPUTS*(NUM_INPUTS-1)/2*NUM_LAGS-1:0] pair_counts,
	input wire byte_tick,
	output corr_types_pkg::tx_out_t tx,
	output logic busy
);

	localparam int BYTE_W = corr_cfg_pkg::BYTE_W;
	localparam int CNT_W = corr_cfg_pkg::CNT_W;
	localparam int NUM_PAIR_CNT = NUM_INPUTS * (NUM_INPUTS - 1) / 2 * NUM_LAGS;
	localparam int NUM_WORDS = NUM_INPUTS + NUM_PAIR_CNT + 1; // Window length is the last word
	localparam int HDR_W = corr_cfg_pkg::PKT_HDR_BYTES * BYTE_W;
	localparam int FRAME_W = HDR_W + NUM_WORDS * CNT_W;
	localparam int NUM_BYTES = FRAME_W / BYTE_W;
	localparam int IDX_W = $clog2(NUM_BYTES);
	localparam int WORD_TOP = FRAME_W - HDR_W - 1;

	corr_types_pkg::cnt_t win_len;
	logic [FRAME_W-1:0] frame_d;
	logic [FRAME_W-1:0] frame_q;
	logic [IDX_W-1:0] byte_idx;
	logic capture;

	// A stop during a packet is dropped, along with that window's results
	assign capture = window.stop & ~busy;

	// Frame is laid out first byte at the top, words most significant byte first
	always_comb begin
		frame_d = '0;
		frame_d[FRAME_W-1 -: BYTE_W] = corr_cfg_pkg::PKT_SYNC;
		frame_d[FRAME_W-1-BYTE_W -: BYTE_W] = BYTE_W'(NUM_INPUTS);
		frame_d[FRAME_W-1-2*BYTE_W -: BYTE_W] = BYTE_W'(NUM_LAGS);
		for (int n = 0; n < NUM_INPUTS; n++) begin
			frame_d[WORD_TOP - n*CNT_W -: CNT_W] = line_counts[n];
		end
		for (int n = 0; n < NUM_PAIR_CNT; n++) begin
			frame_d[WORD_TOP - (NUM_INPUTS+n)*CNT_W -: CNT_W] = pair_counts[n];
		end
		frame_d[CNT_W-1:0] = win_len;
	end

	always_ff @(posedge intclk) begin
		if (capture) begin
			frame_q <= frame_d;
		end
	end

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			win_len <= '0;
			busy <= 1'b0;
			byte_idx <= '0;
			tx <= '0;
		end else begin
			win_len <= corr_types_pkg::cnt_step(win_len, window.start, window.counting);
			tx.strobe <= 1'b0;
			if (capture) begin
				busy <= 1'b1;
				byte_idx <= '0;
			end else if (busy && byte_tick) begin
				tx.strobe <= 1'b1;
				tx.data <= frame_q[FRAME_W-1 - byte_idx*BYTE_W -: BYTE_W];
				if (byte_idx == IDX_W'(NUM_BYTES-1)) begin
					busy <= 1'b0; // Falls with the last strobe
				end else begin
					byte_idx <= byte_idx + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/correlator_top.sv
`default_nettype none

module correlator_top #(
	parameter int NUM_INPUTS = corr_cfg_pkg::DEF_NUM_INPUTS,
	parameter int NUM_LAGS = corr_cfg_pkg::DEF_NUM_LAGS
) (
	input wire intclk,
	input wire rst_n,
	input wire [NUM_INPUTS-1:0] line_in,
	input wire integrate,
	input wire invert,
	input wire byte_tick,
	output wire corr_types_pkg::tx_out_t tx,
	output wire busy
);

	localparam int NUM_PAIR_CNT = NUM_INPUTS * (NUM_INPUTS - 1) / 2 * NUM_LAGS;

	wire [NUM_INPUTS-1:0] pulses;
	wire corr_types_pkg::window_ctrl_t window;
	wire corr_types_pkg::cnt_t [NUM_INPUTS-1:0] line_counts;
	wire corr_types_pkg::cnt_t [NUM_PAIR_CNT-1:0] pair_counts;

	line_sampler #(.NUM_INPUTS(NUM_INPUTS)) sampler0 (
		.intclk(intclk),
		.rst_n(rst_n),
		.line_in(line_in),
		.integrate(integrate),
		.invert(invert),
		.pulses(pulses),
		.window(window)
	);

	pulse_counter #(.NUM_INPUTS(NUM_INPUTS)) counter0 (
		.intclk(intclk),
		.rst_n(rst_n),
		.pulses(pulses),
		.window(window),
		.line_counts(line_counts)
	);

	// Counter and correlator see the same pulses and window, so their results close together
	lag_correlator #(.NUM_INPUTS(NUM_INPUTS), .NUM_LAGS(NUM_LAGS)) correlator0 (
		.intclk(intclk),
		.rst_n(rst_n),
		.pulses(pulses),
		.window(window),
		.pair_counts(pair_counts)
	);

	packet_builder #(.NUM_INPUTS(NUM_INPUTS), .NUM_LAGS(NUM_LAGS)) builder0 (
		.intclk(intclk),
		.rst_n(rst_n),
		.window(window),
		.line_counts(line_counts),
		.pair_counts(pair_counts),
		.byte_tick(byte_tick),
		.tx(tx),
		.busy(busy)
	);

endmodule

`default_nettype wire

//--- testbench/tb_correlator.sv
`default_nettype none

module tb_correlator;

	localparam int NUM_INPUTS = corr_cfg_pkg::DEF_NUM_INPUTS;
	localparam int NUM_LAGS = corr_cfg_pkg::DEF_NUM_LAGS;
	localparam int CNT_W = corr_cfg_pkg::CNT_W;
	localparam int BYTE_W = corr_cfg_pkg::BYTE_W;
	localparam int NUM_PAIRS = NUM_INPUTS * (NUM_INPUTS - 1) / 2;
	localparam int NUM_WORDS = NUM_INPUTS + NUM_PAIRS * NUM_LAGS + 1;
	localparam int PKT_BYTES = corr_cfg_pkg::PKT_HDR_BYTES + 2 * NUM_WORDS;
	localparam int EMPTY_LEN = 50;
	localparam int RAND_LEN = 2000;
	localparam int SAT_LEN = 140000;
	localparam int OVERLAP_LEN = 20;
	localparam int QUIET_LEN = 200;
	localparam int PKT_CYCLES = 3 * PKT_BYTES + 20; // One byte tick in three
	localparam int WATCHDOG_CYCLES = 16 + EMPTY_LEN + RAND_LEN + SAT_LEN + QUIET_LEN
		+ 6 * (PKT_CYCLES + 200) + 1000;

	logic intclk;
	logic rst_n;
	logic [NUM_INPUTS-1:0] line_in;
	logic integrate;
	logic invert;
	logic byte_tick;
	corr_types_pkg::tx_out_t tx;
	logic busy;

	// Reference model, kept in the cycle domain of the driven inputs
	corr_types_pkg::cnt_t exp_line [NUM_INPUTS];
	corr_types_pkg::cnt_t exp_pair [NUM_PAIRS*NUM_LAGS];
	corr_types_pkg::cnt_t exp_len;
	logic [NUM_INPUTS-1:0] m_hist [NUM_LAGS]; // Window edges indexed by their age in cycles
	logic [NUM_INPUTS-1:0] m_level;
	logic m_integ;

	logic inv_sel;
	logic [15:0] lfsr;
	logic [BYTE_W-1:0] rx_bytes [$];
	int n_checks;
	int n_errors;
	int n_tests;

	correlator_top #(.NUM_INPUTS(NUM_INPUTS), .NUM_LAGS(NUM_LAGS)) dut0 (
		.intclk(intclk),
		.rst_n(rst_n),
		.line_in(line_in),
		.integrate(integrate),
		.invert(invert),
		.byte_tick(byte_tick),
		.tx(tx),
		.busy(busy)
	);

	initial begin
		intclk = 1'b0;
		forever #20 intclk = ~intclk;
	end

	initial begin
		#(WATCHDOG_CYCLES * 40);
		$display("Watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16 + x^14 + x^13 + x^11 + 1
	endfunction

	function automatic corr_types_pkg::cnt_t saturating_inc(input corr_types_pkg::cnt_t c);
		return (c == '1) ? c : c + 1'b1;
	endfunction

	function automatic logic [NUM_INPUTS-1:0] one_hot(input int n);
		logic [NUM_INPUTS-1:0] v;
		v = '0;
		v[n] = 1'b1;
		return v;
	endfunction

	// Word w of the received packet, counting from the first word after the header
	function automatic corr_types_pkg::cnt_t received_word(input int w);
		int b;
		b = corr_cfg_pkg::PKT_HDR_BYTES + 2 * w;
		if (b + 1 >= rx_bytes.size()) begin
			return '0;
		end
		return {rx_bytes[b], rx_bytes[b+1]};
	endfunction

	task automatic check_byte(input string what, input logic [BYTE_W-1:0] got,
		input logic [BYTE_W-1:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAIL t=%0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input string what, input corr_types_pkg::cnt_t got,
		input corr_types_pkg::cnt_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAIL t=%0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic clear_model();
		for (int n = 0; n < NUM_INPUTS; n++) begin
			exp_line[n] = '0;
		end
		for (int n = 0; n < NUM_PAIRS * NUM_LAGS; n++) begin
			exp_pair[n] = '0;
		end
		for (int k = 0; k < NUM_LAGS; k++) begin
			m_hist[k] = '0;
		end
		exp_len = '0;
	endtask

	// Drives one input cycle and advances the model by the same cycle
	task automatic drive_cycle(input logic [NUM_INPUTS-1:0] lines, input logic integ);
		logic [NUM_INPUTS-1:0] level;
		logic [NUM_INPUTS-1:0] edges;
		int p;
		@(posedge intclk);
		line_in <= lines;
		integrate <= integ;
		invert <= inv_sel;
		level = lines ^ {NUM_INPUTS{inv_sel}};
		edges = level & ~m_level;
		if (integ && !m_integ) begin
			clear_model(); // A new window starts from zero
		end
		for (int k = NUM_LAGS - 1; k > 0; k--) begin
			m_hist[k] = m_hist[k-1];
		end
		m_hist[0] = integ ? edges : '0;
		if (integ) begin
			exp_len = saturating_inc(exp_len);
			for (int n = 0; n < NUM_INPUTS; n++) begin
				if (edges[n]) begin
					exp_line[n] = saturating_inc(exp_line[n]);
				end
			end
			p = 0;
			for (int i = 0; i < NUM_INPUTS; i++) begin
				for (int j = i + 1; j < NUM_INPUTS; j++) begin
					for (int k = 0; k < NUM_LAGS; k++) begin
						if (edges[i] && m_hist[k][j]) begin
							exp_pair[p] = saturating_inc(exp_pair[p]);
						end
						p++;
					end
				end
			end
		end
		m_level = level;
		m_integ = integ;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) drive_cycle('0, 1'b0);
	endtask

	// Waits for busy, ticks one cycle in three and gathers every strobed byte
	task automatic collect_packet(input int overlap);
		int cyc;
		rx_bytes.delete();
		cyc = 0;
		while (busy !== 1'b1 && cyc < 12) begin
			@(negedge intclk);
			cyc++;
		end
		if (busy !== 1'b1) begin
			n_errors++;
			$display("Packet did not start within 12 cycles of the window closing");
			return;
		end
		cyc = 0;
		while (cyc < PKT_CYCLES) begin
			@(posedge intclk);
			byte_tick <= (cyc % 3 == 0);
			integrate <= (cyc < overlap); // A second window that closes during the packet
			@(negedge intclk);
			if (tx.strobe === 1'b1) begin
				rx_bytes.push_back(tx.data);
			end
			cyc++;
			if (busy !== 1'b1) begin
				break;
			end
		end
		@(posedge intclk);
		byte_tick <= 1'b0;
		integrate <= 1'b0;
		if (busy === 1'b1) begin
			n_errors++;
			$display("Packet still going after %0d cycles", PKT_CYCLES);
		end
	endtask

	task automatic compare_packet();
		int p;
		check_count("packet length", CNT_W'(rx_bytes.size()), CNT_W'(PKT_BYTES));
		if (rx_bytes.size() != PKT_BYTES) begin
			return;
		end
		check_byte("sync byte", rx_bytes[0], corr_cfg_pkg::PKT_SYNC);
		check_byte("line number byte", rx_bytes[1], BYTE_W'(NUM_INPUTS));
		check_byte("lag number byte", rx_bytes[2], BYTE_W'(NUM_LAGS));
		for (int n = 0; n < NUM_INPUTS; n++) begin
			check_count($sformatf("line %0d count", n), received_word(n), exp_line[n]);
		end
		p = 0;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			for (int j = i + 1; j < NUM_INPUTS; j++) begin
				for (int k = 0; k < NUM_LAGS; k++) begin
					check_count($sformatf("pair %0d-%0d lag %0d count", i, j, k),
						received_word(NUM_INPUTS + p), exp_pair[p]);
					p++;
				end
			end
		end
		check_count("window length", received_word(NUM_WORDS - 1), exp_len);
	endtask

	task automatic report_test(input string name, input int err_before);
		n_tests++;
		if (n_errors == err_before) begin
			$display("[%0d] %s: ok", n_tests, name);
		end else begin
			$display("[%0d] %s: %0d errors", n_tests, name, n_errors - err_before);
		end
	endtask

	task automatic header_and_length();
		int err_before;
		err_before = n_errors;
		repeat (EMPTY_LEN) drive_cycle('0, 1'b1);
		idle_cycles(6);
		collect_packet(0);
		compare_packet();
		check_count("footer", received_word(NUM_WORDS - 1), CNT_W'(EMPTY_LEN));
		report_test("header and length", err_before);
	endtask

	task automatic line_counts_window();
		int err_before;
		err_before = n_errors;
		repeat (3) begin
			drive_cycle('1, 1'b0);
			drive_cycle('0, 1'b0);
		end
		drive_cycle('0, 1'b1);
		for (int n = 0; n < NUM_INPUTS; n++) begin
			repeat (n + 2) begin
				drive_cycle(one_hot(n), 1'b1);
				repeat (2) drive_cycle('0, 1'b1);
			end
		end
		repeat (3) begin
			drive_cycle('1, 1'b0); // The first one lands on the stop cycle, after the window
			drive_cycle('0, 1'b0);
		end
		idle_cycles(6);
		collect_packet(0);
		compare_packet();
		for (int n = 0; n < NUM_INPUTS; n++) begin
			check_count($sformatf("line %0d pulses", n), received_word(n), CNT_W'(n + 2));
		end
		report_test("line counts", err_before);
	endtask

	task automatic lag_coincidences();
		int err_before;
		err_before = n_errors;
		repeat (2) drive_cycle('0, 1'b1);
		for (int k = 0; k < NUM_LAGS; k++) begin
			repeat (k + 1) begin
				// Line 2 leads and line 0 follows k cycles later
				if (k == 0) begin
					drive_cycle(one_hot(0) | one_hot(2), 1'b1);
				end else begin
					drive_cycle(one_hot(2), 1'b1);
					repeat (k - 1) drive_cycle('0, 1'b1);
					drive_cycle(one_hot(0), 1'b1);
				end
				repeat (6) drive_cycle('0, 1'b1);
			end
		end
		drive_cycle('0, 1'b0);
		idle_cycles(6);
		collect_packet(0);
		compare_packet();
		// Pair 0-2 is the second pair and collects k+1 hits at lag k
		for (int w = 0; w < NUM_PAIRS * NUM_LAGS; w++) begin
			check_count($sformatf("pair slot %0d", w), received_word(NUM_INPUTS + w),
				CNT_W'((w / NUM_LAGS == 1) ? w % NUM_LAGS + 1 : 0));
		end
		report_test("lag coincidences", err_before);
	endtask

	task automatic inverted_lines();
		int err_before;
		err_before = n_errors;
		inv_sel = 1'b1;
		idle_cycles(4);
		drive_cycle('1, 1'b0); // Raw lines idle high so the inverted levels sit low
		drive_cycle('1, 1'b1);
		for (int n = 0; n < NUM_INPUTS; n++) begin
			repeat (n + 1) begin
				drive_cycle(~one_hot(n), 1'b1);
				repeat (2) drive_cycle('1, 1'b1);
			end
		end
		drive_cycle('1, 1'b0);
		idle_cycles(6);
		collect_packet(0);
		compare_packet();
		for (int n = 0; n < NUM_INPUTS; n++) begin
			check_count($sformatf("line %0d falls", n), received_word(n), CNT_W'(n + 1));
		end
		inv_sel = 1'b0;
		idle_cycles(4);
		report_test("invert", err_before);
	endtask

	task automatic random_lines();
		int err_before;
		logic [NUM_INPUTS-1:0] bits;
		err_before = n_errors;
		drive_cycle('0, 1'b1);
		repeat (RAND_LEN) begin
			for (int n = 0; n < NUM_INPUTS; n++) begin
				lfsr = lfsr_next(lfsr);
				bits[n] = lfsr[0];
			end
			drive_cycle(bits, 1'b1);
		end
		drive_cycle('0, 1'b0);
		idle_cycles(6);
		collect_packet(0);
		compare_packet();
		report_test("random lines", err_before);
	endtask

	task automatic saturation_and_overlap();
		int err_before;
		int extra;
		err_before = n_errors;
		for (int c = 0; c < SAT_LEN; c++) begin
			drive_cycle(c[0] ? (one_hot(0) | one_hot(1)) : '0, 1'b1);
		end
		drive_cycle('0, 1'b0);
		idle_cycles(6);
		collect_packet(OVERLAP_LEN);
		compare_packet();
		check_count("saturated line 0", received_word(0), '1);
		check_count("saturated footer", received_word(NUM_WORDS - 1), '1);
		extra = 0;
		for (int c = 0; c < QUIET_LEN; c++) begin
			@(posedge intclk);
			byte_tick <= (c % 3 == 0);
			@(negedge intclk);
			if (busy !== 1'b0 || tx.strobe !== 1'b0) begin
				extra++;
			end
		end
		check_count("busy cycles after the dropped window", CNT_W'(extra), '0);
		report_test("saturation and overlap", err_before);
	endtask

	initial begin
		rst_n = 1'b0;
		line_in = '0;
		integrate = 1'b0;
		invert = 1'b0;
		byte_tick = 1'b0;
		inv_sel = 1'b0;
		lfsr = 16'd33;
		n_checks = 0;
		n_errors = 0;
		n_tests = 0;
		m_level = '0;
		m_integ = 1'b0;
		clear_model();
		repeat (16) @(posedge intclk);
		rst_n <= 1'b1;
		idle_cycles(4);
		header_and_length();
		line_counts_window();
		lag_coincidences();
		inverted_lines();
		random_lines();
		saturation_and_overlap();
		$display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
verilog/corr_cfg_pkg.sv
verilog/corr_types_pkg.sv
verilog/line_sampler.sv
verilog/pulse_counter.sv
verilog/lag_correlator.sv
verilog/packet_builder.sv
verilog/correlator_top.sv
testbench/tb_correlator.sv

//--- run_sim.sh
#!/bin/sh
# Compile the correlator testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_correlator -f files.f -o sim_correlator
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/sim_correlator > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAIL" sim.log; then
	exit 1
fi
exit 0
